// ==== hdl/erx.sv ====
`include "erx_consts.svh"

module erx
   import erx_pkg::*;
(
   input  logic        sys_clk,
   input  logic        arst_n,
   input  logic        soft_reset,
   input  logic        tx_active,
   output logic        rx_active,
   input  logic        rxi_frame,       // Link, sampled on sys_clk
   input  logic [7:0]  rxi_data,
   output logic        rxo_wr_wait,     // Push-back to remote
   output logic        rxo_rd_wait,
   output logic        rxwr_access,     // Remote writes
   output erx_packet_t rxwr_packet,
   input  logic        rxwr_wait,
   output logic        rxrd_access,     // Remote read requests
   output erx_packet_t rxrd_packet,
   input  logic        rxrd_wait,
   output logic        rxrr_access,     // Read responses to this chip
   output erx_packet_t rxrr_packet,
   input  logic        rxrr_wait,
   input  logic        erx_cfg_access,  // Config port
   input  erx_packet_t erx_cfg_packet,
   output logic        erx_cfg_wait,
   output logic        mailbox_full,
   output logic        mailbox_not_empty
);

   logic        core_nreset;
   logic        rx_access;      // Front end to core
   erx_packet_t rx_packet;
   logic        wr_push;        // Core to queues
   erx_packet_t wr_packet;
   logic        rd_push;
   erx_packet_t rd_packet;
   logic        rr_push;
   erx_packet_t rr_packet;
   logic        wr_almost_full; // Queues back to core
   logic        rd_almost_full;
   logic        rr_almost_full;

   erx_reset erx_reset (
      .sys_clk     (sys_clk),
      .arst_n      (arst_n),
      .soft_reset  (soft_reset),
      .tx_active   (tx_active),
      .core_nreset (core_nreset),
      .rx_active   (rx_active)
   );

   erx_deser erx_deser (
      .sys_clk     (sys_clk),
      .core_nreset (core_nreset),
      .rx_active   (rx_active),
      .rxi_frame   (rxi_frame),
      .rxi_data    (rxi_data),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet)
   );

   erx_core erx_core (
      .sys_clk           (sys_clk),
      .core_nreset       (core_nreset),
      .rx_access         (rx_access),
      .rx_packet         (rx_packet),
      .erx_cfg_access    (erx_cfg_access),
      .erx_cfg_packet    (erx_cfg_packet),
      .wr_almost_full    (wr_almost_full),
      .rd_almost_full    (rd_almost_full),
      .rr_almost_full    (rr_almost_full),
      .wr_push           (wr_push),
      .wr_packet         (wr_packet),
      .rd_push           (rd_push),
      .rd_packet         (rd_packet),
      .rr_push           (rr_push),
      .rr_packet         (rr_packet),
      .erx_cfg_wait      (erx_cfg_wait),
      .rxo_wr_wait       (rxo_wr_wait),
      .rxo_rd_wait       (rxo_rd_wait),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   erx_fifo #(.depth(`ERX_FIFO_DEPTH)) wr_fifo (
      .sys_clk (sys_clk), .core_nreset (core_nreset),
      .push (wr_push), .push_packet (wr_packet), .wait_in (rxwr_wait),
      .access (rxwr_access), .packet (rxwr_packet), .almost_full (wr_almost_full)
   );

   erx_fifo #(.depth(`ERX_FIFO_DEPTH)) rd_fifo (
      .sys_clk (sys_clk), .core_nreset (core_nreset),
      .push (rd_push), .push_packet (rd_packet), .wait_in (rxrd_wait),
      .access (rxrd_access), .packet (rxrd_packet), .almost_full (rd_almost_full)
   );

   erx_fifo #(.depth(`ERX_FIFO_DEPTH)) rr_fifo (
      .sys_clk (sys_clk), .core_nreset (core_nreset),
      .push (rr_push), .push_packet (rr_packet), .wait_in (rxrr_wait),
      .access (rxrr_access), .packet (rxrr_packet), .almost_full (rr_almost_full)
   );

endmodule

// ==== hdl/erx_consts.svh ====
`ifndef ERX_CONSTS_SVH
`define ERX_CONSTS_SVH

// Identity of this chip, upper 12 bits of every local address
`define ERX_CHIP_ID        12'h800

// Mailbox register, offset inside this chip's 1MB window
`define ERX_MAILBOX_OFFSET 20'hF0320

// Outgoing queue sizing
`define ERX_FIFO_DEPTH     8     // Entries per queue, power of two
`define ERX_FIFO_MARGIN    2     // Free entries left when almost_full rises

// Mailbox entries, power of two
`define ERX_MAILBOX_DEPTH  4

// Bytes per link frame, MSB first
`define ERX_PACKET_BYTES   13

// Margin covers one packet still being framed
// plus the one already moving through the pipeline

`endif

// ==== hdl/erx_core.sv ====
`include "erx_consts.svh"

module erx_core
   import erx_pkg::*;
(
   input  logic        sys_clk,
   input  logic        core_nreset,
   input  logic        rx_access,
   input  erx_packet_t rx_packet,
   input  logic        erx_cfg_access,
   input  erx_packet_t erx_cfg_packet,
   input  logic        wr_almost_full,
   input  logic        rd_almost_full,
   input  logic        rr_almost_full,
   output logic        wr_push,
   output erx_packet_t wr_packet,
   output logic        rd_push,
   output erx_packet_t rd_packet,
   output logic        rr_push,
   output erx_packet_t rr_packet,
   output logic        erx_cfg_wait,
   output logic        rxo_wr_wait,
   output logic        rxo_rd_wait,
   output logic        mailbox_full,
   output logic        mailbox_not_empty
);

   localparam int           mb_depth      = `ERX_MAILBOX_DEPTH;
   localparam int           mb_aw         = $clog2(mb_depth);
   localparam logic [mb_aw:0] mb_full_lvl = mb_depth[mb_aw:0];
   localparam erx_chip_id_t chip_id       = `ERX_CHIP_ID;
   localparam erx_addr_t    mailbox_addr  = {`ERX_CHIP_ID, `ERX_MAILBOX_OFFSET};

   logic             local_id;      // Link packet targets this chip
   logic             link_rd;
   logic             link_mb;
   logic             link_rr;
   logic             link_wr;
   logic             cfg_accept;
   logic             cfg_mb_read;   // Mailbox pop request
   logic             mb_push;
   logic             mb_pop;
   logic [mb_aw-1:0] mb_wr_ptr;
   logic [mb_aw-1:0] mb_rd_ptr;
   logic [mb_aw:0]   mb_count;
   erx_data_t        mb_mem [mb_depth];
   erx_packet_t      cfg_resp;      // Mailbox read response

   // Link routing decode
   assign local_id = (rx_packet.dstaddr[31:20] == chip_id);
   assign link_rd  = rx_access & ~rx_packet.write;
   assign link_mb  = rx_access & rx_packet.write & (rx_packet.dstaddr == mailbox_addr);
   assign link_rr  = rx_access & rx_packet.write & local_id & ~link_mb;
   assign link_wr  = rx_access & rx_packet.write & ~local_id;

   // Config port yields to link traffic heading for rr
   assign erx_cfg_wait = rr_almost_full | link_rr;
   assign cfg_accept   = erx_cfg_access & ~erx_cfg_wait;
   assign cfg_mb_read  = cfg_accept & ~erx_cfg_packet.write &
                         (erx_cfg_packet.dstaddr == mailbox_addr);

   // Push-back to the remote transmitter
   assign rxo_wr_wait = wr_almost_full | rr_almost_full;
   assign rxo_rd_wait = rd_almost_full;

   // Mailbox, writes beyond full are lost
   assign mailbox_full      = (mb_count == mb_full_lvl);
   assign mailbox_not_empty = (mb_count != '0);
   assign mb_push           = link_mb & ~mailbox_full;
   assign mb_pop            = cfg_mb_read & mailbox_not_empty;

   always_ff @(posedge sys_clk or negedge core_nreset) begin
      if (!core_nreset) begin
         mb_wr_ptr <= '0;
         mb_rd_ptr <= '0;
         mb_count  <= '0;
      end else begin
         if (mb_push) begin
            mb_wr_ptr <= mb_wr_ptr + 1'b1;
         end
         if (mb_pop) begin
            mb_rd_ptr <= mb_rd_ptr + 1'b1;
         end
         case ({mb_push, mb_pop})
            2'b10:   mb_count <= mb_count + 1'b1;
            2'b01:   mb_count <= mb_count - 1'b1;
            default: mb_count <= mb_count;       // Idle or both
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (mb_push) begin
         mb_mem[mb_wr_ptr] <= rx_packet.data;
      end
   end

   // Response swaps addresses, zero data when nothing stored
   always_comb begin
      cfg_resp         = erx_cfg_packet;         // Keeps datamode/ctrlmode
      cfg_resp.write   = 1'b1;
      cfg_resp.dstaddr = erx_cfg_packet.srcaddr;
      cfg_resp.srcaddr = erx_cfg_packet.dstaddr;
      cfg_resp.data    = mailbox_not_empty ? mb_mem[mb_rd_ptr] : '0;
   end

   // Queue pushes, one cycle after the decode
   always_ff @(posedge sys_clk or negedge core_nreset) begin
      if (!core_nreset) begin
         wr_push <= 1'b0;
         rd_push <= 1'b0;
         rr_push <= 1'b0;
      end else begin
         wr_push <= link_wr;
         rd_push <= link_rd;
         rr_push <= link_rr | cfg_mb_read;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (link_wr) begin
         wr_packet <= rx_packet;
      end
      if (link_rd) begin
         rd_packet <= rx_packet;
      end
      if (link_rr | cfg_mb_read) begin
         rr_packet <= link_rr ? rx_packet : cfg_resp;
      end
   end

   // Link pushes come only from frames begun while push-back was low
   assert property (@(posedge sys_clk) disable iff (!core_nreset)
      (wr_push || (rr_push && !$past(cfg_mb_read)))
      |-> !$past(rxo_wr_wait, `ERX_PACKET_BYTES + 1));

   assert property (@(posedge sys_clk) disable iff (!core_nreset)
      rd_push |-> !$past(rxo_rd_wait, `ERX_PACKET_BYTES + 1));

endmodule

// ==== hdl/erx_deser.sv ====
`include "erx_consts.svh"

module erx_deser
   import erx_pkg::*;
(
   input  logic        sys_clk,
   input  logic        core_nreset,
   input  logic        rx_active,
   input  logic        rxi_frame,
   input  logic [7:0]  rxi_data,
   output logic        rx_access,
   output erx_packet_t rx_packet
);

   localparam int         pw     = $bits(erx_packet_t);
   localparam logic [3:0] nbytes = 4'(`ERX_PACKET_BYTES);

   erx_deser_state_t state;
   logic [3:0]       byte_cnt;   // Bytes taken so far
   erx_packet_t      shreg;      // First byte ends up on top
   logic             take;       // Byte sampled on this edge

   // Frames are ignored until the link is up
   assign take = rxi_frame & rx_active;

   always_ff @(posedge sys_clk or negedge core_nreset) begin
      if (!core_nreset) begin
         state    <= idle;
         byte_cnt <= '0;
      end else begin
         case (state)
            idle, done: begin
               if (take) begin                   // First byte of a packet
                  state    <= collect;
                  byte_cnt <= 4'd1;
               end else begin
                  state    <= idle;
                  byte_cnt <= '0;
               end
            end
            collect: begin
               if (!take) begin                  // Early frame drop
                  state    <= idle;
                  byte_cnt <= '0;
               end else begin
                  byte_cnt <= byte_cnt + 4'd1;
                  if (byte_cnt == nbytes - 4'd1) begin
                     state <= done;              // Last byte in
                  end
               end
            end
            default: begin
               state    <= idle;
               byte_cnt <= '0;
            end
         endcase
      end
   end

   // Payload shifter, MSB first
   always_ff @(posedge sys_clk) begin
      if (take) begin
         shreg <= erx_packet_t'({shreg[pw-9:0], rxi_data});
      end
   end

   assign rx_access = (state == done);   // One cycle per packet
   assign rx_packet = shreg;             // Stable while rx_access is high

   // Count stays inside one frame and is full whenever done
   assert property (@(posedge sys_clk) disable iff (!core_nreset)
      (byte_cnt <= nbytes) && ((state != done) || (byte_cnt == nbytes)));

   // Packets are at least a frame apart
   assert property (@(posedge sys_clk) disable iff (!core_nreset)
      rx_access |=> !rx_access);

endmodule

// ==== hdl/erx_fifo.sv ====
`include "erx_consts.svh"

module erx_fifo
   import erx_pkg::*;
#(
   parameter int depth = `ERX_FIFO_DEPTH
) (
   input  logic        sys_clk,
   input  logic        core_nreset,
   input  logic        push,
   input  erx_packet_t push_packet,
   input  logic        wait_in,
   output logic        access,
   output erx_packet_t packet,
   output logic        almost_full
);

   localparam int          aw        = $clog2(depth);
   localparam int          af_int    = depth - `ERX_FIFO_MARGIN;
   localparam logic [aw:0] full_lvl  = depth[aw:0];
   localparam logic [aw:0] af_lvl    = af_int[aw:0];

   erx_packet_t   mem [depth];
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [aw:0]   count;         // Extra bit to tell full from empty
   logic          full;
   logic          do_push;
   logic          do_pop;

   assign full        = (count == full_lvl);
   assign almost_full = (count >= af_lvl);     // Free entries <= margin
   assign access      = (count != '0);         // Show-ahead head
   assign packet      = mem[rd_ptr];
   assign do_push     = push & ~full;          // Overflow is dropped
   assign do_pop      = access & ~wait_in;

   always_ff @(posedge sys_clk or negedge core_nreset) begin
      if (!core_nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;           // Wraps at depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_packet;
      end
   end

   // Upstream push-back keeps the queue from overflowing
   assert property (@(posedge sys_clk) disable iff (!core_nreset)
      push |-> !full);

endmodule

// ==== hdl/erx_pkg.sv ====
package erx_pkg;

   // Address map: chip ID in [31:20], offset in [19:0]
   typedef logic [31:0] erx_addr_t;

   // Payload word
   typedef logic [31:0] erx_data_t;

   // Chip identifier, top of erx_addr_t
   typedef logic [11:0] erx_chip_id_t;

   // 104-bit transaction, same bit order as on the wire
   typedef struct packed {
      logic       write;      // Write or read response
      logic [1:0] datamode;   // Access size
      logic [4:0] ctrlmode;   // Passed through untouched
      erx_addr_t  dstaddr;    // Target
      erx_data_t  data;       // Write data or returned word
      erx_addr_t  srcaddr;    // Return address for reads
   } erx_packet_t;

   // Link front end byte collector
   typedef enum logic [1:0] {
      idle,                   // No frame
      collect,                // Shifting bytes in
      done                    // Full packet, rx_access high
   } erx_deser_state_t;

   // Frame ending in collect drops the partial packet
   // done also takes the first byte of a back-to-back packet

endpackage

// ==== hdl/erx_reset.sv ====
module erx_reset (
   input  logic sys_clk,
   input  logic arst_n,
   input  logic soft_reset,      // Level, held by software
   input  logic tx_active,       // Transmitter is up
   output logic core_nreset,
   output logic rx_active
);

   logic [1:0] rst_sync;         // Shifts in ones on release
   logic [1:0] act_sync;         // tx_active synchronizer

   // Assert async, release after two edges
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_sync <= 2'b00;
      end else if (soft_reset) begin
         rst_sync <= 2'b00;      // Soft reset restarts the release
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   assign core_nreset = rst_sync[1];

   // Activity level, cleared for as long as the core is in reset
   always_ff @(posedge sys_clk or negedge core_nreset) begin
      if (!core_nreset) begin
         act_sync <= 2'b00;
      end else begin
         act_sync <= {act_sync[0], tx_active};
      end
   end

   assign rx_active = act_sync[1];   // Gates the front end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/erx_pkg.sv
hdl/erx_reset.sv
hdl/erx_deser.sv
hdl/erx_core.sv
hdl/erx_fifo.sv
hdl/erx.sv
testbench/tb_erx.sv

// ==== run.sh ====
#!/bin/bash
# Compile and run the erx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_erx -f project.f

if ! ./obj_dir/Vtb_erx > sim.log 2>&1; then
   cat sim.log
   echo "Simulation exited abnormally"
   exit 1
fi
cat sim.log

# Verdict comes from the log
if grep -q "Finished with errors" sim.log; then
   exit 1
fi
grep -q "Finished with no errors" sim.log

// ==== testbench/tb_erx.sv ====
`include "erx_consts.svh"

module tb_erx
   import erx_pkg::*;
();

   localparam int        timeout_cycles = 4000;   // Roughly twice the directed run
   localparam int        drain_limit    = 300;    // Per-test bound on delivery
   localparam int        kind_wr        = 0;      // Remote write
   localparam int        kind_rd        = 1;      // Read request
   localparam int        kind_rr        = 2;      // Write to this chip, read response
   localparam int        nbytes         = `ERX_PACKET_BYTES;
   localparam erx_addr_t mailbox_addr   = {`ERX_CHIP_ID, `ERX_MAILBOX_OFFSET};

   logic        sys_clk;
   logic        arst_n;
   logic        soft_reset;
   logic        tx_active;
   logic        rx_active;
   logic        rxi_frame;
   logic [7:0]  rxi_data;
   logic        rxo_wr_wait;
   logic        rxo_rd_wait;
   logic        rxwr_access;
   erx_packet_t rxwr_packet;
   logic        rxwr_wait;
   logic        rxrd_access;
   erx_packet_t rxrd_packet;
   logic        rxrd_wait;
   logic        rxrr_access;
   erx_packet_t rxrr_packet;
   logic        rxrr_wait;
   logic        erx_cfg_access;
   erx_packet_t erx_cfg_packet;
   logic        erx_cfg_wait;
   logic        mailbox_full;
   logic        mailbox_not_empty;

   logic [31:0] rng_state    = 32'ha5c8bfd2;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycle_count  = 0;
   erx_packet_t exp_wr[$];                        // Scoreboards, one per outgoing port
   erx_packet_t exp_rd[$];
   erx_packet_t exp_rr[$];

   erx i_erx (.*);

   initial begin
      sys_clk = 1'b0;
      forever #50 sys_clk = ~sys_clk;
   end

   // Hang guard
   always @(posedge sys_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout: run still busy after %0d cycles", cycle_count);
         $display("Finished with errors");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic check_packet(input string name, input erx_packet_t exp, input erx_packet_t got);
      if (got !== exp) begin
         value_errors++;
         $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_flag(input string name, input bit exp, input logic got);
      if (got !== exp) begin
         value_errors++;
         $display("FAIL %0t %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   // Transfers happen on edges with access high and wait low
   always @(posedge sys_clk) begin
      if (rxwr_access && !rxwr_wait) begin
         if (exp_wr.size() == 0) begin
            other_errors++;
            $display("ERROR %0t: unexpected packet on rxwr %h", $time, rxwr_packet);
         end else begin
            check_packet("rxwr_packet", exp_wr.pop_front(), rxwr_packet);
         end
      end
      if (rxrd_access && !rxrd_wait) begin
         if (exp_rd.size() == 0) begin
            other_errors++;
            $display("ERROR %0t: unexpected packet on rxrd %h", $time, rxrd_packet);
         end else begin
            check_packet("rxrd_packet", exp_rd.pop_front(), rxrd_packet);
         end
      end
      if (rxrr_access && !rxrr_wait) begin
         if (exp_rr.size() == 0) begin
            other_errors++;
            $display("ERROR %0t: unexpected packet on rxrr %h", $time, rxrr_packet);
         end else begin
            check_packet("rxrr_packet", exp_rr.pop_front(), rxrr_packet);
         end
      end
   end

   function automatic erx_packet_t make_packet(input int kind);
      erx_packet_t p;
      logic [31:0] r;
      r          = next_rand();
      p.write    = (kind != kind_rd);
      p.datamode = r[1:0];
      p.ctrlmode = r[6:2];
      p.dstaddr  = next_rand();
      p.data     = next_rand();
      p.srcaddr  = next_rand();
      if (kind == kind_wr && p.dstaddr[31:20] == `ERX_CHIP_ID) begin
         p.dstaddr[31] = ~p.dstaddr[31];        // Move off this chip
      end
      if (kind == kind_rr) begin
         p.dstaddr[31:20] = `ERX_CHIP_ID;
         if (p.dstaddr == mailbox_addr) begin
            p.dstaddr[0] = ~p.dstaddr[0];       // Keep clear of the mailbox
         end
      end
      return p;
   endfunction

   // Routing rule for link packets
   task automatic expect_route(input erx_packet_t p);
      if (!p.write) begin
         exp_rd.push_back(p);
      end else if (p.dstaddr == mailbox_addr) begin
         // Swallowed by the mailbox
      end else if (p.dstaddr[31:20] == `ERX_CHIP_ID) begin
         exp_rr.push_back(p);
      end else begin
         exp_wr.push_back(p);
      end
   endtask

   // Streams n bytes MSB first, frame left high for back-to-back packets
   task automatic send_frame(input erx_packet_t p, input int n);
      while ((p.write && rxo_wr_wait) || (!p.write && rxo_rd_wait)) begin
         rxi_frame = 1'b0;                      // Hold off while pushed back
         @(negedge sys_clk);
      end
      for (int i = 0; i < n; i++) begin
         rxi_frame = 1'b1;
         rxi_data  = p[$bits(erx_packet_t)-1-8*i -: 8];
         @(negedge sys_clk);
      end
   endtask

   task automatic end_frame();
      rxi_frame = 1'b0;
      rxi_data  = 8'h00;
      @(negedge sys_clk);
   endtask

   task automatic cfg_read(input erx_packet_t req);
      int n;
      n              = 0;
      erx_cfg_packet = req;
      erx_cfg_access = 1'b1;
      while (erx_cfg_wait && n < drain_limit) begin
         @(negedge sys_clk);
         n++;
      end
      if (erx_cfg_wait) begin
         other_errors++;
         $display("ERROR %0t: config read was never accepted", $time);
      end
      @(negedge sys_clk);                       // Accepted on the edge just passed
      erx_cfg_access = 1'b0;
   endtask

   task automatic wait_drain(input string test);
      int n;
      n = 0;
      while ((exp_wr.size() + exp_rd.size() + exp_rr.size()) != 0 && n < drain_limit) begin
         @(negedge sys_clk);
         n++;
      end
      if ((exp_wr.size() + exp_rd.size() + exp_rr.size()) != 0) begin
         other_errors++;
         $display("ERROR %0t: %s left %0d/%0d/%0d packets undelivered on rxwr/rxrd/rxrr",
                  $time, test, exp_wr.size(), exp_rd.size(), exp_rr.size());
         exp_wr.delete();
         exp_rd.delete();
         exp_rr.delete();
      end
      repeat (4) @(negedge sys_clk);            // Room for stray extras to show
   endtask

   task automatic test_reset_state();
      int n;
      repeat (4) @(negedge sys_clk);            // Past core_nreset release
      check_flag("rxwr_access", 1'b0, rxwr_access);
      check_flag("rxrd_access", 1'b0, rxrd_access);
      check_flag("rxrr_access", 1'b0, rxrr_access);
      check_flag("rxo_wr_wait", 1'b0, rxo_wr_wait);
      check_flag("rxo_rd_wait", 1'b0, rxo_rd_wait);
      check_flag("erx_cfg_wait", 1'b0, erx_cfg_wait);
      check_flag("mailbox_full", 1'b0, mailbox_full);
      check_flag("mailbox_not_empty", 1'b0, mailbox_not_empty);
      check_flag("rx_active", 1'b0, rx_active);
      send_frame(make_packet(kind_wr), nbytes);  // Link down, must vanish
      send_frame(make_packet(kind_rd), nbytes);
      end_frame();
      repeat (6) @(negedge sys_clk);
      tx_active = 1'b1;
      n = 0;
      while (!rx_active && n < 10) begin
         @(negedge sys_clk);
         n++;
      end
      if (!rx_active) begin
         other_errors++;
         $display("ERROR %0t: rx_active did not follow tx_active", $time);
      end
   endtask

   task automatic test_routing();
      erx_packet_t p;
      for (int i = 0; i < 12; i++) begin
         p = make_packet(int'(next_rand() % 3));
         expect_route(p);
         send_frame(p, nbytes);                 // Frame stays high, back to back
      end
      end_frame();
      wait_drain("routing");
   endtask

   task automatic test_partial_frame();
      erx_packet_t p;
      send_frame(make_packet(kind_wr), 7);      // Cut short
      end_frame();
      p = make_packet(kind_rr);
      expect_route(p);
      send_frame(p, nbytes);
      end_frame();
      wait_drain("partial frame");
   endtask

   task automatic test_backpressure();
      erx_packet_t p;
      int          n;
      rxwr_wait = 1'b1;
      fork
         begin
            for (int i = 0; i < 10; i++) begin
               p = make_packet(kind_wr);
               expect_route(p);
               send_frame(p, nbytes);
            end
            end_frame();
         end
         begin
            n = 0;
            while (!rxo_wr_wait && n < drain_limit) begin
               @(negedge sys_clk);
               n++;
            end
            if (!rxo_wr_wait) begin
               other_errors++;
               $display("ERROR %0t: rxo_wr_wait never rose with rxwr held", $time);
            end
            check_flag("rxwr_access", 1'b1, rxwr_access);
            repeat (30) @(negedge sys_clk);     // In-flight packet finishes
            check_flag("rxi_frame", 1'b0, rxi_frame);   // Driver paused
            check_flag("rxo_wr_wait", 1'b1, rxo_wr_wait);
            @(negedge sys_clk);
            rxwr_wait = 1'b0;
         end
      join
      wait_drain("backpressure");
   endtask

   task automatic test_mailbox();
      erx_packet_t p;
      erx_packet_t req;
      erx_packet_t resp;
      erx_data_t   words[$];                    // Expected mailbox contents
      for (int i = 0; i < 5; i++) begin
         p         = make_packet(kind_rr);
         p.dstaddr = mailbox_addr;
         if (i < `ERX_MAILBOX_DEPTH) begin
            words.push_back(p.data);            // Fifth one is dropped
         end
         expect_route(p);
         send_frame(p, nbytes);
         if (i == 3) begin
            end_frame();
            repeat (3) @(negedge sys_clk);
            check_flag("mailbox_full", 1'b1, mailbox_full);
            check_flag("mailbox_not_empty", 1'b1, mailbox_not_empty);
         end
      end
      end_frame();
      repeat (3) @(negedge sys_clk);
      check_flag("mailbox_full", 1'b1, mailbox_full);
      for (int i = 0; i < 5; i++) begin
         req          = make_packet(kind_rd);
         req.dstaddr  = mailbox_addr;
         resp         = req;                    // Mode fields carried over
         resp.write   = 1'b1;
         resp.dstaddr = req.srcaddr;
         resp.srcaddr = req.dstaddr;
         resp.data    = (words.size() != 0) ? words.pop_front() : '0;
         exp_rr.push_back(resp);
         cfg_read(req);
         if (i == 3) begin
            check_flag("mailbox_not_empty", 1'b0, mailbox_not_empty);
            check_flag("mailbox_full", 1'b0, mailbox_full);
         end
      end
      wait_drain("mailbox");
   endtask

   initial begin
      arst_n         = 1'b0;
      soft_reset     = 1'b0;
      tx_active      = 1'b0;
      rxi_frame      = 1'b0;
      rxi_data       = 8'h00;
      rxwr_wait      = 1'b0;
      rxrd_wait      = 1'b0;
      rxrr_wait      = 1'b0;
      erx_cfg_access = 1'b0;
      erx_cfg_packet = '0;
      repeat (16) @(negedge sys_clk);
      arst_n = 1'b1;
      test_reset_state();
      test_routing();
      test_partial_frame();
      test_backpressure();
      test_mailbox();
      repeat (10) @(negedge sys_clk);
      $display("Error count: %0d value mismatches, %0d other", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
